// File: openadc_pkg.sv
`default_nettype none

package openadc_pkg;

	// Bus widths
	localparam int DATA_W  = 8;  // Host byte and ADC FIFO byte
	localparam int ADDR_W  = 6;  // Address field of the command byte
	localparam int WORD_W  = 32; // Sample count, offset, frequency
	localparam int PHASE_W = 9;  // Phase shift value

	// Register map
	localparam logic [ADDR_W-1:0] ADDR_GAIN     = 6'd0;
	localparam logic [ADDR_W-1:0] ADDR_SETTINGS = 6'd1;
	localparam logic [ADDR_W-1:0] ADDR_STATUS   = 6'd2;  // Read only
	localparam logic [ADDR_W-1:0] ADDR_ADCDATA  = 6'd3;  // Stream on read
	localparam logic [ADDR_W-1:0] ADDR_ECHO     = 6'd4;

	// External clock frequency, LSB first, read only
	localparam logic [ADDR_W-1:0] ADDR_EXTFREQ0 = 6'd5;
	localparam logic [ADDR_W-1:0] ADDR_EXTFREQ1 = 6'd6;
	localparam logic [ADDR_W-1:0] ADDR_EXTFREQ2 = 6'd7;
	localparam logic [ADDR_W-1:0] ADDR_EXTFREQ3 = 6'd8;

	localparam logic [ADDR_W-1:0] ADDR_PHASE_LO = 6'd9;
	localparam logic [ADDR_W-1:0] ADDR_PHASE_HI = 6'd10; // Bit 0 phase MSB, bit 1 load/done

	// Samples to capture, LSB first
	localparam logic [ADDR_W-1:0] ADDR_SAMPLES0 = 6'd16;
	localparam logic [ADDR_W-1:0] ADDR_SAMPLES1 = 6'd17;
	localparam logic [ADDR_W-1:0] ADDR_SAMPLES2 = 6'd18;
	localparam logic [ADDR_W-1:0] ADDR_SAMPLES3 = 6'd19;

	// Trigger offset, LSB first
	localparam logic [ADDR_W-1:0] ADDR_OFFSET0  = 6'd26;
	localparam logic [ADDR_W-1:0] ADDR_OFFSET1  = 6'd27;
	localparam logic [ADDR_W-1:0] ADDR_OFFSET2  = 6'd28;
	localparam logic [ADDR_W-1:0] ADDR_OFFSET3  = 6'd29;

	// Bit positions in the settings register
	localparam int SET_RESET     = 0;
	localparam int SET_HILOW     = 1;
	localparam int SET_TRIG_MODE = 2;
	localparam int SET_ARM       = 3;
	localparam int SET_TRIG_WAIT = 5;
	localparam int SET_CLK_SRC   = 6;

	localparam logic [DATA_W-1:0] SYNC_BYTE = 8'hAC; // Leads every ADC stream

	typedef enum logic [2:0] {
		IDLE,
		ADDR,
		DATA_WAIT,
		DATA_WRITE,
		READ_START,
		STREAM_SEND,
		STREAM_FETCH
	} cmd_state_e;

endpackage

`default_nettype wire

// File: cmd_fsm.sv
`default_nettype none

module cmd_fsm import openadc_pkg::*; (
	input  wire logic              ftdi_clk,
	input  wire logic              reset,
	// Host FIFO
	input  wire logic              rxf_i,
	input  wire logic              txe_i,
	input  wire logic [DATA_W-1:0] din_i,
	output logic                   rd_o,
	output logic                   wr_o,
	output logic                   isout_o,
	output logic      [DATA_W-1:0] dout_o,
	// ADC FIFO, first word fall through
	input  wire logic              fifo_empty_i,
	input  wire logic [DATA_W-1:0] fifo_data_i,
	output logic                   fifo_rd_en_o,
	// Register write port
	output logic                   wr_en_o,
	output logic      [ADDR_W-1:0] wr_addr_o,
	output logic      [DATA_W-1:0] wr_data_o,
	// Register read port
	output logic      [ADDR_W-1:0] rd_addr_o,
	output logic                   rd_strobe_o,
	input  wire logic [DATA_W-1:0] rd_data_i,
	input  wire logic              rd_valid_addr_i
);

	cmd_state_e        state;
	logic [ADDR_W-1:0] addr_q; // Address field of the current command

	// Write strobe lives for the DATA_WRITE cycle only
	assign wr_en_o   = (state == DATA_WRITE);
	assign wr_addr_o = addr_q;
	assign wr_data_o = din_i; // Data byte popped in DATA_WAIT

	assign rd_addr_o   = addr_q;
	assign rd_strobe_o = (state == READ_START);

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state        <= IDLE;
			rd_o         <= 1'b0;
			wr_o         <= 1'b0;
			isout_o      <= 1'b0;
			fifo_rd_en_o <= 1'b0;
		end else begin
			// Strobes are single cycle unless set below
			rd_o         <= 1'b0;
			wr_o         <= 1'b0;
			fifo_rd_en_o <= 1'b0;
			case (state)
				IDLE: begin
					isout_o <= 1'b0; // Ends the reply after its last wr_o
					if (rxf_i) begin
						rd_o  <= 1'b1; // Pop the command byte
						state <= ADDR;
					end
				end

				ADDR: begin
					if (din_i[7]) begin
						if (din_i[6]) begin
							state <= DATA_WAIT; // Write, data byte follows
						end else begin
							isout_o <= 1'b1;
							state   <= READ_START;
						end
					end else begin
						state <= IDLE; // Not a command, drop it
					end
				end

				DATA_WAIT: begin
					if (rxf_i) begin
						rd_o  <= 1'b1; // Pop the data byte
						state <= DATA_WRITE;
					end
				end

				DATA_WRITE: begin
					state <= IDLE; // Register takes din_i on this edge
				end

				READ_START: begin
					if (addr_q == ADDR_ADCDATA) begin
						state <= STREAM_SEND;
					end else begin
						wr_o  <= rd_valid_addr_i; // No reply for unmapped addresses
						state <= IDLE;
					end
				end

				STREAM_SEND: begin
					if (txe_i) begin
						wr_o <= 1'b1; // Push byte held in dout_o
						if (!fifo_empty_i) begin
							fifo_rd_en_o <= 1'b1;
							state        <= STREAM_FETCH;
						end else begin
							state <= IDLE; // FIFO drained, stream done
						end
					end
				end

				STREAM_FETCH: begin
					state <= STREAM_SEND;
				end

				default: begin
					isout_o <= 1'b0;
					state   <= IDLE;
				end
			endcase
		end
	end

	// Command address and reply byte
	always_ff @(posedge ftdi_clk) begin
		if (state == ADDR) begin
			addr_q <= din_i[ADDR_W-1:0];
		end
		if (state == READ_START) begin
			if (addr_q == ADDR_ADCDATA) begin
				dout_o <= SYNC_BYTE;
			end else begin
				dout_o <= rd_data_i;
			end
		end else if (state == STREAM_FETCH) begin
			dout_o <= fifo_data_i; // Byte consumed by fifo_rd_en_o this cycle
		end
	end

	// Half duplex host port: never pop and push at once
	a_rd_wr_excl: assert property (@(posedge ftdi_clk) disable iff (reset)
		!(rd_o && wr_o));

	// Every pushed byte belongs to a read reply
	a_wr_isout: assert property (@(posedge ftdi_clk) disable iff (reset)
		wr_o |-> isout_o);

endmodule

`default_nettype wire

// File: reg_bank.sv
`default_nettype none

module reg_bank import openadc_pkg::*; (
	input  wire logic              ftdi_clk,
	input  wire logic              reset,
	// Write port from the sequencer
	input  wire logic              wr_en_i,
	input  wire logic [ADDR_W-1:0] wr_addr_i,
	input  wire logic [DATA_W-1:0] wr_data_i,
	// Read port
	input  wire logic [ADDR_W-1:0] rd_addr_i,
	input  wire logic              rd_strobe_i,
	output logic      [DATA_W-1:0] rd_data_o,
	output logic                   rd_valid_addr_o,
	// Read-only sources
	input  wire logic [DATA_W-1:0] status_i,
	input  wire logic [WORD_W-1:0] extclk_frequency_i,
	input  wire logic [WORD_W-1:0] maxsamples_i,
	input  wire logic [DATA_W-1:0] phase_rd_lo_i,
	input  wire logic [DATA_W-1:0] phase_rd_hi_i,
	// Control outputs
	output logic                   soft_reset_o,
	output logic      [DATA_W-1:0] gain_o,
	output logic                   hilow_o,
	output logic                   trigger_mode_o,
	output logic                   cmd_arm_o,
	output logic                   trigger_wait_o,
	output logic                   adc_clk_src_o,
	output logic      [WORD_W-1:0] maxsamples_o,
	output logic      [WORD_W-1:0] trigger_offset_o
);

	logic [DATA_W-1:0] settings;
	logic [DATA_W-1:0] echo;
	logic [WORD_W-1:0] freq_snap;   // Frozen copy of extclk_frequency_i
	logic              freq_locked;
	logic              lock_rd;     // Read of a lower frequency byte

	// Settings bit fields
	assign soft_reset_o   = settings[SET_RESET];
	assign hilow_o        = settings[SET_HILOW];
	assign trigger_mode_o = settings[SET_TRIG_MODE];
	assign cmd_arm_o      = settings[SET_ARM];
	assign trigger_wait_o = settings[SET_TRIG_WAIT];
	assign adc_clk_src_o  = settings[SET_CLK_SRC];

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			gain_o           <= '0;
			settings         <= '0;
			maxsamples_o     <= maxsamples_i; // Default to full capture depth
			trigger_offset_o <= '0;
		end else if (wr_en_i) begin
			case (wr_addr_i)
				ADDR_GAIN:     gain_o   <= wr_data_i;
				ADDR_SETTINGS: settings <= wr_data_i;
				ADDR_SAMPLES0: maxsamples_o[7:0]   <= wr_data_i;
				ADDR_SAMPLES1: maxsamples_o[15:8]  <= wr_data_i;
				ADDR_SAMPLES2: maxsamples_o[23:16] <= wr_data_i;
				ADDR_SAMPLES3: maxsamples_o[31:24] <= wr_data_i;
				ADDR_OFFSET0:  trigger_offset_o[7:0]   <= wr_data_i;
				ADDR_OFFSET1:  trigger_offset_o[15:8]  <= wr_data_i;
				ADDR_OFFSET2:  trigger_offset_o[23:16] <= wr_data_i;
				ADDR_OFFSET3:  trigger_offset_o[31:24] <= wr_data_i;
				default: ; // Read-only or unmapped
			endcase
		end
	end

	// Scratch register for link checks
	always_ff @(posedge ftdi_clk) begin
		if (wr_en_i && (wr_addr_i == ADDR_ECHO)) begin
			echo <= wr_data_i;
		end
	end

	assign lock_rd = rd_strobe_i && ((rd_addr_i == ADDR_EXTFREQ0) ||
		(rd_addr_i == ADDR_EXTFREQ1) || (rd_addr_i == ADDR_EXTFREQ2));

	// Lock holds across bytes 0..2, the MSB read or any other read releases it
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			freq_locked <= 1'b0;
		end else if (rd_strobe_i) begin
			freq_locked <= lock_rd;
		end
	end

	// Also frozen on the locking edge so byte 0 and later bytes match
	always_ff @(posedge ftdi_clk) begin
		if (!freq_locked && !lock_rd) begin
			freq_snap <= extclk_frequency_i;
		end
	end

	// Readback mux
	always_comb begin
		rd_valid_addr_o = 1'b1;
		case (rd_addr_i)
			ADDR_GAIN:     rd_data_o = gain_o;
			ADDR_SETTINGS: rd_data_o = settings;
			ADDR_STATUS:   rd_data_o = status_i;
			ADDR_ECHO:     rd_data_o = echo;
			ADDR_EXTFREQ0: rd_data_o = freq_snap[7:0];
			ADDR_EXTFREQ1: rd_data_o = freq_snap[15:8];
			ADDR_EXTFREQ2: rd_data_o = freq_snap[23:16];
			ADDR_EXTFREQ3: rd_data_o = freq_snap[31:24];
			ADDR_PHASE_LO: rd_data_o = phase_rd_lo_i;
			ADDR_PHASE_HI: rd_data_o = phase_rd_hi_i;
			ADDR_SAMPLES0: rd_data_o = maxsamples_o[7:0];
			ADDR_SAMPLES1: rd_data_o = maxsamples_o[15:8];
			ADDR_SAMPLES2: rd_data_o = maxsamples_o[23:16];
			ADDR_SAMPLES3: rd_data_o = maxsamples_o[31:24];
			ADDR_OFFSET0:  rd_data_o = trigger_offset_o[7:0];
			ADDR_OFFSET1:  rd_data_o = trigger_offset_o[15:8];
			ADDR_OFFSET2:  rd_data_o = trigger_offset_o[23:16];
			ADDR_OFFSET3:  rd_data_o = trigger_offset_o[31:24];
			default: begin
				rd_data_o       = '0;
				rd_valid_addr_o = 1'b0; // ADC data is streamed, not muxed
			end
		endcase
	end

	// Writes to status, ADC data or frequency leave every register alone
	a_ro_write: assert property (@(posedge ftdi_clk) disable iff (reset)
		wr_en_i && ((wr_addr_i == ADDR_STATUS) || (wr_addr_i == ADDR_ADCDATA) ||
		((wr_addr_i >= ADDR_EXTFREQ0) && (wr_addr_i <= ADDR_EXTFREQ3)))
		|=> $stable(gain_o) && $stable(settings) && $stable(echo) &&
		$stable(maxsamples_o) && $stable(trigger_offset_o));

endmodule

`default_nettype wire

// File: phase_ctrl.sv
`default_nettype none

module phase_ctrl import openadc_pkg::*; (
	input  wire logic               ftdi_clk,
	input  wire logic               reset,
	input  wire logic               wr_en_i,
	input  wire logic [ADDR_W-1:0]  wr_addr_i,
	input  wire logic [DATA_W-1:0]  wr_data_i,
	input  wire logic [PHASE_W-1:0] phase_i,      // Phase reported by the shifter
	input  wire logic               phase_done_i,
	output logic      [PHASE_W-1:0] phase_o,
	output logic                    phase_ld_o,
	output logic      [DATA_W-1:0]  phase_rd_lo_o,
	output logic      [DATA_W-1:0]  phase_rd_hi_o
);

	logic [PHASE_W-1:0] phase_in;
	logic               phase_done;

	// Outgoing phase value
	always_ff @(posedge ftdi_clk) begin
		if (wr_en_i && (wr_addr_i == ADDR_PHASE_LO)) begin
			phase_o[7:0] <= wr_data_i;
		end
		if (wr_en_i && (wr_addr_i == ADDR_PHASE_HI)) begin
			phase_o[8] <= wr_data_i[0];
		end
	end

	// Load pulse from PHASE_HI bit 1
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			phase_ld_o <= 1'b0;
		end else begin
			phase_ld_o <= wr_en_i && (wr_addr_i == ADDR_PHASE_HI) && wr_data_i[1];
		end
	end

	// Returned phase, cleared whenever a new load goes out
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			phase_in   <= '0;
			phase_done <= 1'b0;
		end else if (phase_ld_o) begin
			phase_in   <= '0;
			phase_done <= 1'b0;
		end else if (phase_done_i) begin
			phase_in   <= phase_i;
			phase_done <= 1'b1;
		end
	end

	assign phase_rd_lo_o = phase_in[7:0];
	assign phase_rd_hi_o = {6'b0, phase_done, phase_in[8]}; // Status in bit 1

	a_ld_single: assert property (@(posedge ftdi_clk) disable iff (reset)
		phase_ld_o |=> !phase_ld_o);

endmodule

`default_nettype wire

// File: usb_interface.sv
`default_nettype none

module usb_interface import openadc_pkg::*; (
	input  wire logic               ftdi_clk,
	input  wire logic               reset_i,
	output logic                    reset_o,
	// Host FIFO
	input  wire logic               rxf_i,
	input  wire logic               txe_i,
	input  wire logic [DATA_W-1:0]  din_i,
	output logic                    rd_o,
	output logic                    wr_o,
	output logic      [DATA_W-1:0]  dout_o,
	output logic                    isout_o,
	input  wire logic [DATA_W-1:0]  status_i,
	// ADC FIFO
	input  wire logic               fifo_empty_i,
	input  wire logic [DATA_W-1:0]  fifo_data_i,
	output logic                    fifo_rd_en_o,
	// Gain and trigger control
	output logic      [DATA_W-1:0]  gain_o,
	output logic                    hilow_o,
	output logic                    cmd_arm_o,
	output logic                    trigger_mode_o,
	output logic                    trigger_wait_o,
	output logic      [WORD_W-1:0]  trigger_offset_o,
	input  wire logic [WORD_W-1:0]  extclk_frequency_i,
	// Phase shifter
	input  wire logic [PHASE_W-1:0] phase_i,
	input  wire logic               phase_done_i,
	output logic      [PHASE_W-1:0] phase_o,
	output logic                    phase_ld_o,
	// ADC clocking and capture depth
	output logic                    adc_clk_src_o,
	input  wire logic [WORD_W-1:0]  maxsamples_i,
	output logic      [WORD_W-1:0]  maxsamples_o
);

	logic              reset;         // Combined reset for all blocks
	logic              soft_reset;    // Settings bit 0
	logic              reset_latched;
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [DATA_W-1:0] wr_data;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_strobe;
	logic [DATA_W-1:0] rd_data;
	logic              rd_valid_addr;
	logic [DATA_W-1:0] phase_rd_lo;
	logic [DATA_W-1:0] phase_rd_hi;

	// One cycle delay, so the reset it causes clears settings and ends itself
	always_ff @(posedge ftdi_clk or posedge reset_i) begin
		if (reset_i) begin
			reset_latched <= 1'b0;
		end else begin
			reset_latched <= soft_reset;
		end
	end

	assign reset   = reset_i | reset_latched;
	assign reset_o = reset;

	cmd_fsm u_cmd_fsm (
		.ftdi_clk        (ftdi_clk),
		.reset           (reset),
		.rxf_i           (rxf_i),
		.txe_i           (txe_i),
		.din_i           (din_i),
		.rd_o            (rd_o),
		.wr_o            (wr_o),
		.isout_o         (isout_o),
		.dout_o          (dout_o),
		.fifo_empty_i    (fifo_empty_i),
		.fifo_data_i     (fifo_data_i),
		.fifo_rd_en_o    (fifo_rd_en_o),
		.wr_en_o         (wr_en),
		.wr_addr_o       (wr_addr),
		.wr_data_o       (wr_data),
		.rd_addr_o       (rd_addr),
		.rd_strobe_o     (rd_strobe),
		.rd_data_i       (rd_data),
		.rd_valid_addr_i (rd_valid_addr)
	);

	reg_bank u_reg_bank (
		.ftdi_clk           (ftdi_clk),
		.reset              (reset),
		.wr_en_i            (wr_en),
		.wr_addr_i          (wr_addr),
		.wr_data_i          (wr_data),
		.rd_addr_i          (rd_addr),
		.rd_strobe_i        (rd_strobe),
		.rd_data_o          (rd_data),
		.rd_valid_addr_o    (rd_valid_addr),
		.status_i           (status_i),
		.extclk_frequency_i (extclk_frequency_i),
		.maxsamples_i       (maxsamples_i),
		.phase_rd_lo_i      (phase_rd_lo),
		.phase_rd_hi_i      (phase_rd_hi),
		.soft_reset_o       (soft_reset),
		.gain_o             (gain_o),
		.hilow_o            (hilow_o),
		.trigger_mode_o     (trigger_mode_o),
		.cmd_arm_o          (cmd_arm_o),
		.trigger_wait_o     (trigger_wait_o),
		.adc_clk_src_o      (adc_clk_src_o),
		.maxsamples_o       (maxsamples_o),
		.trigger_offset_o   (trigger_offset_o)
	);

	phase_ctrl u_phase_ctrl (
		.ftdi_clk      (ftdi_clk),
		.reset         (reset),
		.wr_en_i       (wr_en),
		.wr_addr_i     (wr_addr),
		.wr_data_i     (wr_data),
		.phase_i       (phase_i),
		.phase_done_i  (phase_done_i),
		.phase_o       (phase_o),
		.phase_ld_o    (phase_ld_o),
		.phase_rd_lo_o (phase_rd_lo),
		.phase_rd_hi_o (phase_rd_hi)
	);

endmodule

`default_nettype wire

// File: tb_host_tasks.svh
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

function automatic logic [DATA_W-1:0] cmd_byte(input logic write, input logic [ADDR_W-1:0] addr);
	return {1'b1, write, addr};  // Bit 7 marks a command
endfunction

function automatic logic [DATA_W-1:0] byte_of(input logic [WORD_W-1:0] word, input int idx);
	return word[idx*8 +: 8];  // LSB first
endfunction

// Until the host queue drains and the reply is over
task automatic wait_idle();
	int quiet;
	int n;
	quiet = 0;
	n     = 0;
	while ((quiet < 3) && (n < 200)) begin
		@(posedge ftdi_clk);
		#DRIVE_DLY;
		n++;
		if ((host_q.size() == 0) && !pop_pending && !isout_o && !rd_o) quiet++;
		else quiet = 0;
	end
	if (quiet < 3) begin
		$display("Host transfer did not finish within 200 cycles");
		errors++;
	end
endtask

task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
	host_q.push_back(cmd_byte(1'b1, addr));
	host_q.push_back(data);
	wait_idle();
endtask

task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
	int n0;
	n0 = rx_bytes.size();
	host_q.push_back(cmd_byte(1'b0, addr));
	wait_idle();
	data = 8'h00;
	if (rx_bytes.size() != n0 + 1) begin
		$display("Read of address %0d gave %0d reply bytes", addr, rx_bytes.size() - n0);
		errors++;
	end else begin
		data = rx_bytes[n0];
	end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	assert (got === exp) else begin
		$display("Error: %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("Error: %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	assert (got === exp) else begin
		$display("Error: %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

// Settings outputs against the bits just written
task automatic check_ctrl_bits(input logic hilow, input logic mode, input logic arm,
		input logic trig_wait, input logic clk_src);
	check_bit("hilow_o", hilow_o, hilow);
	check_bit("trigger_mode_o", trigger_mode_o, mode);
	check_bit("cmd_arm_o", cmd_arm_o, arm);
	check_bit("trigger_wait_o", trigger_wait_o, trig_wait);
	check_bit("adc_clk_src_o", adc_clk_src_o, clk_src);
endtask

task automatic end_test(input string name);
	int n;
	n = errors - test_errors0;
	if (n == 0) $display("%s: pass", name);
	else begin
		$display("%s: fail with %0d errors", name, n);
		tests_failed++;
	end
	test_errors0 = errors;
endtask

`endif

// File: tb_usb_interface.sv
`default_nettype none

module tb_usb_interface import openadc_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DLY  = 10;  // Input skew after the rising edge

	// Per-test cycle budgets summed for the watchdog
	localparam int T1_CYC = 150;
	localparam int T2_CYC = 400;
	localparam int T3_CYC = 200;
	localparam int T4_CYC = 200;
	localparam int T5_CYC = 200;
	localparam int T6_CYC = 300;
	localparam int WATCHDOG_NS =
		4 * (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC) * CLK_PERIOD;

	logic               ftdi_clk           = 1'b0;
	logic               reset_i            = 1'b1;
	logic               rxf_i              = 1'b0;
	logic               txe_i              = 1'b1;
	logic [DATA_W-1:0]  din_i              = '0;
	logic [DATA_W-1:0]  status_i           = 8'h3C;
	logic               fifo_empty_i       = 1'b1;
	logic [DATA_W-1:0]  fifo_data_i        = '0;
	logic [WORD_W-1:0]  extclk_frequency_i = '0;
	logic [PHASE_W-1:0] phase_i            = '0;
	logic               phase_done_i       = 1'b0;
	logic [WORD_W-1:0]  maxsamples_i       = 32'h0000_2000;

	logic               reset_o;
	logic               rd_o;
	logic               wr_o;
	logic [DATA_W-1:0]  dout_o;
	logic               isout_o;
	logic [DATA_W-1:0]  gain_o;
	logic               hilow_o;
	logic               fifo_rd_en_o;
	logic               cmd_arm_o;
	logic               trigger_mode_o;
	logic               trigger_wait_o;
	logic [WORD_W-1:0]  trigger_offset_o;
	logic [PHASE_W-1:0] phase_o;
	logic               phase_ld_o;
	logic               adc_clk_src_o;
	logic [WORD_W-1:0]  maxsamples_o;

	// Host and ADC FIFO model state
	logic [DATA_W-1:0]  host_q[$];    // Bytes waiting for the DUT
	logic [DATA_W-1:0]  rx_bytes[$];  // Bytes pushed by the DUT
	logic [DATA_W-1:0]  adc_q[$];
	logic               pop_pending   = 1'b0;
	logic               txe_throttle  = 1'b0;
	logic [PHASE_W-1:0] exp_phase     = '0;
	integer             seed          = 32'h9deb_20f8;
	int                 errors        = 0;
	int                 tests_failed  = 0;
	int                 test_errors0  = 0;
	int                 reset_pulses  = 0;
	int                 ld_pulses     = 0;
	int                 fifo_pops     = 0;

	`include "tb_host_tasks.svh"

	initial begin
		forever begin
			#(CLK_PERIOD / 2) ftdi_clk = ~ftdi_clk;
		end
	end

	usb_interface u_usb_interface (.*);

	// Host receive side drops the byte the cycle after rd_o
	always @(posedge ftdi_clk) begin
		logic rd_seen;
		rd_seen = rd_o;
		#DRIVE_DLY;
		if (rd_seen) begin
			pop_pending = 1'b1;  // Data stays valid one more cycle
		end else if (pop_pending) begin
			void'(host_q.pop_front());
			pop_pending = 1'b0;
		end
		rxf_i = (host_q.size() > 0) && !pop_pending;
		din_i = (host_q.size() > 0) ? host_q[0] : 8'h00;
	end

	// Host transmit side
	always @(posedge ftdi_clk) begin
		if (wr_o) begin
			rx_bytes.push_back(dout_o);
		end
	end

	always @(posedge ftdi_clk) begin
		int r;
		#DRIVE_DLY;
		r     = $random(seed);
		txe_i = txe_throttle ? r[0] : 1'b1;
	end

	// FWFT ADC FIFO drops its head after the consuming edge
	always @(posedge ftdi_clk) begin
		logic pop_seen;
		pop_seen = fifo_rd_en_o;
		#DRIVE_DLY;
		if (pop_seen && (adc_q.size() > 0)) begin
			void'(adc_q.pop_front());
		end
		fifo_empty_i = (adc_q.size() == 0);
		fifo_data_i  = (adc_q.size() > 0) ? adc_q[0] : 8'h00;
	end

	always @(posedge reset_o) reset_pulses++;
	always @(posedge ftdi_clk) if (phase_ld_o) ld_pulses++;
	always @(posedge ftdi_clk) if (fifo_rd_en_o) fifo_pops++;

	a_wr_in_reply: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		wr_o |-> isout_o)
		else begin
			$display("Byte pushed to host outside a read reply");
			errors++;
		end

	a_pop_not_empty: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		fifo_rd_en_o |-> !fifo_empty_i)
		else begin
			$display("ADC FIFO read while it was empty");
			errors++;
		end

	a_phase_value: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		phase_ld_o |-> (phase_o == exp_phase))
		else begin
			$display("Error: phase_o got %h expected %h", phase_o, exp_phase);
			errors++;
		end

	a_ld_pulse: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		phase_ld_o |=> !phase_ld_o)
		else begin
			$display("phase_ld_o stayed high for more than one cycle");
			errors++;
		end

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog expired before the test sequence finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		logic [DATA_W-1:0] rd;
		logic [WORD_W-1:0] word;
		logic [DATA_W-1:0] exp_q[$];
		int                n0;
		int                r;

		repeat (4) @(posedge ftdi_clk);
		#DRIVE_DLY;
		reset_i = 1'b0;
		repeat (2) @(posedge ftdi_clk);

		// Echo, status and a non-command byte
		write_reg(ADDR_ECHO, 8'hA5);
		read_reg(ADDR_ECHO, rd);
		check_byte("echo", rd, 8'hA5);
		write_reg(ADDR_STATUS, 8'hFF);  // Status is read only
		read_reg(ADDR_STATUS, rd);
		check_byte("status", rd, status_i);
		n0 = rx_bytes.size();
		host_q.push_back(8'h04);  // Bit 7 clear
		wait_idle();
		if (rx_bytes.size() != n0) begin
			$display("Non-command byte produced a reply");
			errors++;
		end
		end_test("echo, status and invalid command");

		// Settings bits, gain and trigger offset
		write_reg(ADDR_SETTINGS, 8'h2A);
		check_ctrl_bits(1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
		write_reg(ADDR_SETTINGS, 8'h44);
		check_ctrl_bits(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
		write_reg(ADDR_GAIN, 8'h5C);
		check_byte("gain_o", gain_o, 8'h5C);
		word = 32'hDEAD_BEEF;
		for (int i = 0; i < 4; i++) begin
			write_reg(ADDR_OFFSET0 + 6'(i), byte_of(word, i));
		end
		check_word("trigger_offset_o", trigger_offset_o, word);
		for (int i = 0; i < 4; i++) begin
			read_reg(ADDR_OFFSET0 + 6'(i), rd);
			check_byte("offset byte", rd, byte_of(word, i));
		end
		end_test("settings, gain and offset");

		// Sample count default and soft reset
		check_word("maxsamples_o", maxsamples_o, maxsamples_i);
		write_reg(ADDR_SAMPLES0, 8'h77);
		check_word("maxsamples_o", maxsamples_o, {maxsamples_i[31:8], 8'h77});
		n0 = reset_pulses;
		write_reg(ADDR_SETTINGS, 8'h01);
		if (reset_pulses != n0 + 1) begin
			$display("Soft reset did not give exactly one reset_o pulse");
			errors++;
		end
		check_word("maxsamples_o", maxsamples_o, maxsamples_i);
		read_reg(ADDR_SETTINGS, rd);
		check_byte("settings", rd, 8'h00);
		end_test("soft reset");

		// Phase load and capture
		exp_phase = 9'h15A;
		n0 = ld_pulses;
		write_reg(ADDR_PHASE_LO, exp_phase[7:0]);
		write_reg(ADDR_PHASE_HI, {6'b0, 1'b1, exp_phase[8]});
		if (ld_pulses != n0 + 1) begin
			$display("Phase write did not give a single phase_ld_o pulse");
			errors++;
		end
		@(posedge ftdi_clk);
		#DRIVE_DLY;
		phase_i      = 9'h1C3;
		phase_done_i = 1'b1;
		@(posedge ftdi_clk);
		#DRIVE_DLY;
		phase_done_i = 1'b0;
		read_reg(ADDR_PHASE_HI, rd);
		check_byte("phase hi", rd, {6'b0, 1'b1, phase_i[8]});
		read_reg(ADDR_PHASE_LO, rd);
		check_byte("phase lo", rd, phase_i[7:0]);
		end_test("phase load and capture");

		// Frequency snapshot across four reads
		extclk_frequency_i = 32'h1122_3344;
		repeat (2) @(posedge ftdi_clk);
		word = extclk_frequency_i;
		for (int i = 0; i < 4; i++) begin
			read_reg(ADDR_EXTFREQ0 + 6'(i), rd);
			check_byte("extfreq byte", rd, byte_of(word, i));
			extclk_frequency_i = extclk_frequency_i + 32'h0101_0101;  // Moves on
		end
		end_test("frequency snapshot");

		// ADC stream with host back-pressure
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			adc_q.push_back(r[7:0]);
			exp_q.push_back(r[7:0]);
		end
		@(posedge ftdi_clk);
		#DRIVE_DLY;
		txe_throttle = 1'b1;
		n0 = rx_bytes.size();
		r  = fifo_pops;
		host_q.push_back(cmd_byte(1'b0, ADDR_ADCDATA));
		wait_idle();
		txe_throttle = 1'b0;
		if (rx_bytes.size() != n0 + 1 + exp_q.size()) begin
			$display("Stream length %0d, expected %0d", rx_bytes.size() - n0,
				exp_q.size() + 1);
			errors++;
		end else begin
			check_byte("stream sync", rx_bytes[n0], SYNC_BYTE);
			for (int i = 0; i < exp_q.size(); i++) begin
				check_byte("stream byte", rx_bytes[n0 + 1 + i], exp_q[i]);
			end
		end
		if (fifo_pops - r != exp_q.size()) begin
			$display("fifo_rd_en_o pulsed %0d times, expected %0d", fifo_pops - r,
				exp_q.size());
			errors++;
		end
		end_test("ADC stream");

		$display("Tests: 6, failed: %0d, errors: %0d", tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
openadc_pkg.sv
cmd_fsm.sv
reg_bank.sv
phase_ctrl.sv
usb_interface.sv
tb_usb_interface.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_usb_interface
FLIST     := tb.f
FLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
